// File: apb_pkg.sv
`default_nettype none

package apb_pkg;

	// Requester side transfer phases
	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		ACCESS
	} apb_phase_t;

	localparam int ADDR_W_DEFAULT = 16;

endpackage

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int DATA_W  = 16;
	localparam int REG_AW  = 5;
	localparam int SHAMT_W = 4;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [REG_AW-1:0] reg_addr_t;

	// Jumps leave their return address here
	localparam reg_addr_t RET_REG = 5'd16;

	// For the ALU group the low three bits are the ALU operation
	typedef enum logic [4:0] {
		OP_ADD  = 5'b00000,
		OP_SUB  = 5'b00001,
		OP_AND  = 5'b00010,
		OP_OR   = 5'b00011,
		OP_XOR  = 5'b00100,
		OP_SLL  = 5'b00101,
		OP_SRL  = 5'b00110,
		OP_ADDI = 5'b00111,
		OP_LDU  = 5'b01000,
		OP_LDL  = 5'b01001,
		OP_LD   = 5'b01010,
		OP_ST   = 5'b01011,
		OP_B    = 5'b01100,
		OP_J    = 5'b01101,
		OP_JI   = 5'b01110,
		OP_HALT = 5'b01111,
		OP_NOP  = 5'b11111
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_OR   = 3'd3,
		ALU_XOR  = 3'd4,
		ALU_SLL  = 3'd5,
		ALU_SRL  = 3'd6,
		ALU_ADDI = 3'd7
	} alu_op_t;

	// Signed compares use N xor V
	typedef enum logic [2:0] {
		COND_EQ,
		COND_NE,
		COND_LT,
		COND_GE,
		COND_GT,
		COND_LE,
		COND_OV,
		COND_AL
	} cond_t;

	////////////////////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////////////////////
	localparam int OPC_HI     = 15;
	localparam int OPC_LO     = 11;
	localparam int RA_HI      = 9;
	localparam int RA_LO      = 5;
	// LDU and LDL carry the first register in a 3-bit field
	localparam int RA_BYTE_HI = 10;
	localparam int RA_BYTE_LO = 8;
	localparam int RB_HI      = 4;
	localparam int RB_LO      = 0;
	localparam int IMM5_HI    = 4;
	localparam int COND_HI    = 10;
	localparam int COND_LO    = 8;
	localparam int BOFF_HI    = 7;
	localparam int JOFF_HI    = 9;
	localparam int BYTE_HI    = 7;

endpackage

`default_nettype wire

// File: control_unit.sv
`default_nettype none

module control_unit (
	input  isa_pkg::opcode_t opcode,
	output logic             alu_to_reg,
	output logic             pcr_to_reg,
	output logic             mem_to_reg,
	output logic             imm_to_reg,
	output logic             reg_we_dst_0,
	output logic             reg_we_dst_1,
	output logic             mem_we,
	output logic             mem_re,
	output logic             add_immd,
	output logic             jump_immd,
	output logic             branch,
	output logic             jump,
	output logic             z_we,
	output logic             n_we,
	output logic             v_we,
	output logic             halt
);
	import isa_pkg::*;

	always_comb begin
		// Anything not listed decodes as NOP
		alu_to_reg   = 1'b0;
		pcr_to_reg   = 1'b0;
		mem_to_reg   = 1'b0;
		imm_to_reg   = 1'b0;
		reg_we_dst_0 = 1'b0;
		reg_we_dst_1 = 1'b0;
		mem_we       = 1'b0;
		mem_re       = 1'b0;
		add_immd     = 1'b0;
		jump_immd    = 1'b0;
		branch       = 1'b0;
		jump         = 1'b0;
		z_we         = 1'b0;
		n_we         = 1'b0;
		v_we         = 1'b0;
		halt         = 1'b0;
		case (opcode)
			OP_ADD, OP_SUB: begin
				alu_to_reg   = 1'b1;
				reg_we_dst_0 = 1'b1;
				z_we         = 1'b1;
				n_we         = 1'b1;
				v_we         = 1'b1;
			end
			OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_ADDI: begin
				alu_to_reg   = 1'b1;
				reg_we_dst_0 = 1'b1;
				add_immd     = (opcode == OP_ADDI);
				z_we         = 1'b1;
				n_we         = 1'b1;
			end
			OP_LDU, OP_LDL: begin
				imm_to_reg   = 1'b1;
				reg_we_dst_0 = 1'b1;
			end
			OP_LD: begin
				mem_to_reg   = 1'b1;
				mem_re       = 1'b1;
				reg_we_dst_0 = 1'b1;
			end
			OP_ST:   mem_we = 1'b1;
			OP_B:    branch = 1'b1;
			OP_J, OP_JI: begin
				jump         = 1'b1;
				jump_immd    = (opcode == OP_JI);
				pcr_to_reg   = 1'b1;
				reg_we_dst_1 = 1'b1;
			end
			OP_HALT: halt = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: register_file.sv
`default_nettype none

module register_file (
	input  logic               clk,
	input  isa_pkg::reg_addr_t addr_0,
	input  isa_pkg::reg_addr_t addr_1,
	input  isa_pkg::reg_addr_t wrt_addr,
	input  isa_pkg::word_t     wrt_data,
	input  logic               we,
	output isa_pkg::word_t     data_0,
	output isa_pkg::word_t     data_1
);
	import isa_pkg::*;

	word_t regs [2**REG_AW];

	// R0 is never written
	always_ff @(posedge clk) begin
		if (we && wrt_addr != '0) begin
			regs[wrt_addr] <= wrt_data;
		end
	end

	// Same cycle write bypasses the array
	function automatic word_t read_port(input reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end
		if (we && addr == wrt_addr) begin
			return wrt_data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		data_0 = read_port(addr_0);
		data_1 = read_port(addr_1);
	end

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu (
	input  isa_pkg::word_t                op0,
	input  isa_pkg::word_t                op1,
	input  isa_pkg::alu_op_t              alu_op,
	input  logic [isa_pkg::SHAMT_W-1:0]   shamt,
	output isa_pkg::word_t                result,
	output logic                          z,
	output logic                          n,
	output logic                          v
);
	import isa_pkg::*;

	localparam int MSB = DATA_W - 1;

	word_t sum;
	word_t diff;

	assign sum  = op0 + op1;
	assign diff = op0 - op1;

	always_comb begin
		result = sum;
		v      = 1'b0;
		case (alu_op)
			ALU_ADD: begin
				result = sum;
				v      = (op0[MSB] == op1[MSB]) && (sum[MSB] != op0[MSB]);
			end
			ALU_SUB: begin
				result = diff;
				v      = (op0[MSB] != op1[MSB]) && (diff[MSB] != op0[MSB]);
			end
			ALU_AND:  result = op0 & op1;
			ALU_OR:   result = op0 | op1;
			ALU_XOR:  result = op0 ^ op1;
			ALU_SLL:  result = op0 << shamt;
			ALU_SRL:  result = op0 >> shamt;
			ALU_ADDI: result = sum;
			default:  result = sum;
		endcase
	end

	assign z = (result == '0);
	assign n = result[MSB];

endmodule

`default_nettype wire

// File: branch_unit.sv
`default_nettype none

module branch_unit (
	input  logic            branch,
	input  logic            jump,
	input  isa_pkg::cond_t  cond,
	input  logic            z,
	input  logic            n,
	input  logic            v,
	input  isa_pkg::word_t  pc_plus_1,
	input  isa_pkg::word_t  branch_offset,
	input  isa_pkg::word_t  jump_offset,
	output logic            pc_select,
	output isa_pkg::word_t  pc_next,
	output isa_pkg::word_t  pc_return
);
	import isa_pkg::*;

	logic  lt;
	logic  cond_met;
	word_t offset;

	assign lt = n ^ v;

	always_comb begin
		case (cond)
			COND_EQ: cond_met = z;
			COND_NE: cond_met = !z;
			COND_LT: cond_met = lt;
			COND_GE: cond_met = !lt;
			COND_GT: cond_met = !z && !lt;
			COND_LE: cond_met = z || lt;
			COND_OV: cond_met = v;
			default: cond_met = 1'b1;
		endcase
	end

	// One adder serves branches and both jump forms
	assign offset    = jump ? jump_offset : branch_offset;
	assign pc_next   = pc_plus_1 + offset;
	assign pc_select = jump || (branch && cond_met);
	assign pc_return = pc_plus_1;

endmodule

`default_nettype wire

// File: decode_execute.sv
`default_nettype none

module decode_execute (
	input  logic               clk,
	input  logic               rst_n,
	input  isa_pkg::word_t     instr,
	input  isa_pkg::word_t     pc_plus_1,
	input  logic               stall_mem,
	input  logic               wb_we,
	input  isa_pkg::reg_addr_t wb_addr,
	input  isa_pkg::word_t     wb_data,
	output logic               stall_hazard,
	output logic               pc_select,
	output isa_pkg::word_t     pc_next,
	output logic               dex_alu_to_reg,
	output logic               dex_pcr_to_reg,
	output logic               dex_mem_to_reg,
	output logic               dex_imm_to_reg,
	output logic               dex_reg_we_dst_0,
	output logic               dex_reg_we_dst_1,
	output logic               dex_mem_we,
	output logic               dex_mem_re,
	output logic               dex_halt,
	output isa_pkg::reg_addr_t dex_dst_addr_0,
	output isa_pkg::reg_addr_t dex_dst_addr_1,
	output isa_pkg::word_t     dex_alu_result,
	output isa_pkg::word_t     dex_pc_return,
	output isa_pkg::word_t     dex_mem_addr,
	output isa_pkg::word_t     dex_mem_wdata,
	output isa_pkg::word_t     dex_load_immd
);
	import isa_pkg::*;

	opcode_t   opcode;
	reg_addr_t reg_addr_0;
	reg_addr_t reg_addr_1;
	word_t     reg_data_0;
	word_t     reg_data_1;
	word_t     alu_op1;
	word_t     alu_result;
	word_t     imm5_ext;
	word_t     branch_offset;
	word_t     jump_offset;
	word_t     load_immd;
	word_t     pc_return;
	logic      alu_to_reg;
	logic      pcr_to_reg;
	logic      mem_to_reg;
	logic      imm_to_reg;
	logic      reg_we_dst_0;
	logic      reg_we_dst_1;
	logic      mem_we;
	logic      mem_re;
	logic      add_immd;
	logic      jump_immd;
	logic      branch;
	logic      jump;
	logic      z_we;
	logic      n_we;
	logic      v_we;
	logic      halt;
	logic      alu_z;
	logic      alu_n;
	logic      alu_v;
	logic      flag_z;
	logic      flag_n;
	logic      flag_v;
	logic      pc_take;
	logic      hold;
	logic      stall_any;

	assign opcode = opcode_t'(instr[OPC_HI:OPC_LO]);

	control_unit u_control (
		.opcode       (opcode),
		.alu_to_reg   (alu_to_reg),
		.pcr_to_reg   (pcr_to_reg),
		.mem_to_reg   (mem_to_reg),
		.imm_to_reg   (imm_to_reg),
		.reg_we_dst_0 (reg_we_dst_0),
		.reg_we_dst_1 (reg_we_dst_1),
		.mem_we       (mem_we),
		.mem_re       (mem_re),
		.add_immd     (add_immd),
		.jump_immd    (jump_immd),
		.branch       (branch),
		.jump         (jump),
		.z_we         (z_we),
		.n_we         (n_we),
		.v_we         (v_we),
		.halt         (halt)
	);

	////////////////////////////////////////////////////////////////////////////
	// Operand fetch
	////////////////////////////////////////////////////////////////////////////
	assign reg_addr_0 = imm_to_reg ? reg_addr_t'(instr[RA_BYTE_HI:RA_BYTE_LO])
	                               : instr[RA_HI:RA_LO];
	assign reg_addr_1 = instr[RB_HI:RB_LO];

	register_file u_regfile (
		.clk      (clk),
		.addr_0   (reg_addr_0),
		.addr_1   (reg_addr_1),
		.wrt_addr (wb_addr),
		.wrt_data (wb_data),
		.we       (wb_we),
		.data_0   (reg_data_0),
		.data_1   (reg_data_1)
	);

	// Any read that matches a pending DEX write waits a cycle
	assign stall_hazard =
		(dex_reg_we_dst_0 && (reg_addr_0 == dex_dst_addr_0 || reg_addr_1 == dex_dst_addr_0)) ||
		(dex_reg_we_dst_1 && (reg_addr_0 == dex_dst_addr_1 || reg_addr_1 == dex_dst_addr_1));

	assign hold      = stall_mem || dex_halt;
	assign stall_any = hold || stall_hazard;

	////////////////////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////////////////////
	assign imm5_ext = {{(DATA_W - IMM5_HI - 1){instr[IMM5_HI]}}, instr[IMM5_HI:0]};
	assign alu_op1  = add_immd ? imm5_ext : reg_data_1;

	alu u_alu (
		.op0    (reg_data_0),
		.op1    (alu_op1),
		.alu_op (alu_op_t'(opcode[2:0])),
		.shamt  (instr[SHAMT_W-1:0]),
		.result (alu_result),
		.z      (alu_z),
		.n      (alu_n),
		.v      (alu_v)
	);

	// Byte immediate lands in the upper byte for LDU, lower for LDL
	assign load_immd = (opcode == OP_LDU) ? {instr[BYTE_HI:0], reg_data_0[7:0]}
	                                      : {reg_data_0[15:8], instr[BYTE_HI:0]};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flag_z <= 1'b0;
			flag_n <= 1'b0;
			flag_v <= 1'b0;
		end else if (!stall_any) begin
			if (z_we) begin
				flag_z <= alu_z;
			end
			if (n_we) begin
				flag_n <= alu_n;
			end
			if (v_we) begin
				flag_v <= alu_v;
			end
		end
	end

	assign branch_offset = {{(DATA_W - BOFF_HI - 1){instr[BOFF_HI]}}, instr[BOFF_HI:0]};
	// J reaches the register value through the shared target adder
	assign jump_offset = jump_immd
		? {{(DATA_W - JOFF_HI - 1){instr[JOFF_HI]}}, instr[JOFF_HI:0]}
		: reg_data_1 - pc_plus_1;

	branch_unit u_branch (
		.branch        (branch),
		.jump          (jump),
		.cond          (cond_t'(instr[COND_HI:COND_LO])),
		.z             (flag_z),
		.n             (flag_n),
		.v             (flag_v),
		.pc_plus_1     (pc_plus_1),
		.branch_offset (branch_offset),
		.jump_offset   (jump_offset),
		.pc_select     (pc_take),
		.pc_next       (pc_next),
		.pc_return     (pc_return)
	);

	assign pc_select = pc_take && !stall_any;

	////////////////////////////////////////////////////////////////////////////
	// DEX pipeline register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dex_alu_to_reg   <= 1'b0;
			dex_pcr_to_reg   <= 1'b0;
			dex_mem_to_reg   <= 1'b0;
			dex_imm_to_reg   <= 1'b0;
			dex_reg_we_dst_0 <= 1'b0;
			dex_reg_we_dst_1 <= 1'b0;
			dex_mem_we       <= 1'b0;
			dex_mem_re       <= 1'b0;
			dex_halt         <= 1'b0;
		end else if (!hold) begin
			dex_alu_to_reg   <= alu_to_reg;
			dex_pcr_to_reg   <= pcr_to_reg;
			dex_mem_to_reg   <= mem_to_reg;
			dex_imm_to_reg   <= imm_to_reg;
			// Hazard turns the slot into a bubble
			dex_reg_we_dst_0 <= reg_we_dst_0 && !stall_hazard;
			dex_reg_we_dst_1 <= reg_we_dst_1 && !stall_hazard;
			dex_mem_we       <= mem_we && !stall_hazard;
			dex_mem_re       <= mem_re && !stall_hazard;
			dex_halt         <= halt && !stall_hazard;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			dex_dst_addr_0 <= reg_addr_0;
			dex_dst_addr_1 <= jump ? RET_REG : reg_addr_1;
			dex_alu_result <= alu_result;
			dex_pc_return  <= pc_return;
			dex_mem_addr   <= reg_data_1;
			dex_mem_wdata  <= reg_data_0;
			dex_load_immd  <= load_immd;
		end
	end

	// A bubble must reach writeback and the APB side with nothing enabled
	assert property (@(posedge clk) disable iff (!rst_n)
		(stall_hazard && !stall_mem && !dex_halt) |=> !wb_we && !stall_mem);

	// Load data is written only on the completing cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		(wb_we && dex_mem_to_reg) |-> !stall_mem);

endmodule

`default_nettype wire

// File: mem_writeback.sv
`default_nettype none

module mem_writeback #(
	parameter int ADDR_W = apb_pkg::ADDR_W_DEFAULT
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               dex_alu_to_reg,
	input  logic               dex_pcr_to_reg,
	input  logic               dex_mem_to_reg,
	input  logic               dex_imm_to_reg,
	input  logic               dex_reg_we_dst_0,
	input  logic               dex_reg_we_dst_1,
	input  logic               dex_mem_we,
	input  logic               dex_mem_re,
	input  isa_pkg::reg_addr_t dex_dst_addr_0,
	input  isa_pkg::reg_addr_t dex_dst_addr_1,
	input  isa_pkg::word_t     dex_alu_result,
	input  isa_pkg::word_t     dex_pc_return,
	input  isa_pkg::word_t     dex_mem_addr,
	input  isa_pkg::word_t     dex_mem_wdata,
	input  isa_pkg::word_t     dex_load_immd,
	input  isa_pkg::word_t     prdata,
	input  logic               pready,
	output logic               psel,
	output logic               penable,
	output logic               pwrite,
	output logic [ADDR_W-1:0]  paddr,
	output isa_pkg::word_t     pwdata,
	output logic               mem_busy,
	output logic               wb_we,
	output isa_pkg::reg_addr_t wb_addr,
	output isa_pkg::word_t     wb_data
);
	import apb_pkg::*;

	apb_phase_t state;
	apb_phase_t phase;
	logic       xfer_done;

	////////////////////////////////////////////////////////////////////////////
	// APB requester
	////////////////////////////////////////////////////////////////////////////

	// SETUP is the first DEX cycle of a memory op, so it is never stored
	always_comb begin
		phase = state;
		if (state == IDLE && (dex_mem_we || dex_mem_re)) begin
			phase = SETUP;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else if (phase == SETUP) begin
			state <= ACCESS;
		end else if (phase == ACCESS && pready) begin
			state <= IDLE;
		end
	end

	assign xfer_done = (phase == ACCESS) && pready;
	assign mem_busy  = (phase == SETUP) || ((phase == ACCESS) && !pready);

	assign psel    = (phase != IDLE);
	assign penable = (phase == ACCESS);
	assign pwrite  = dex_mem_we;
	assign paddr   = ADDR_W'(dex_mem_addr);
	assign pwdata  = dex_mem_wdata;

	////////////////////////////////////////////////////////////////////////////
	// Writeback
	////////////////////////////////////////////////////////////////////////////

	// Loads write only on the completing edge
	assign wb_we =
		(dex_reg_we_dst_0 && (dex_alu_to_reg || dex_imm_to_reg ||
		                      (dex_mem_to_reg && xfer_done))) ||
		(dex_reg_we_dst_1 && dex_pcr_to_reg);

	assign wb_addr = dex_reg_we_dst_1 ? dex_dst_addr_1 : dex_dst_addr_0;

	always_comb begin
		wb_data = dex_alu_result;
		if (dex_pcr_to_reg) begin
			wb_data = dex_pc_return;
		end else if (dex_mem_to_reg) begin
			wb_data = prdata;
		end else if (dex_imm_to_reg) begin
			wb_data = dex_load_immd;
		end
	end

	// Address and write data held from SETUP until pready
	assert property (@(posedge clk) disable iff (!rst_n)
		penable |-> $stable(paddr) && $stable(pwdata));

endmodule

`default_nettype wire

// File: cpu_core.sv
`default_nettype none

module cpu_core #(
	parameter int ADDR_W = apb_pkg::ADDR_W_DEFAULT
) (
	input  logic              clk,
	input  logic              rst_n,
	output isa_pkg::word_t    instr_addr,
	input  isa_pkg::word_t    instr_data,
	output logic              psel,
	output logic              penable,
	output logic              pwrite,
	output logic [ADDR_W-1:0] paddr,
	output isa_pkg::word_t    pwdata,
	input  isa_pkg::word_t    prdata,
	input  logic              pready,
	output logic              halted
);
	import isa_pkg::*;

	word_t     pc;
	word_t     pc_plus_1;
	word_t     pc_next;
	logic      pc_select;
	logic      stall_hazard;
	logic      mem_busy;
	logic      halt_q;
	logic      wb_we;
	reg_addr_t wb_addr;
	word_t     wb_data;
	logic      dex_alu_to_reg;
	logic      dex_pcr_to_reg;
	logic      dex_mem_to_reg;
	logic      dex_imm_to_reg;
	logic      dex_reg_we_dst_0;
	logic      dex_reg_we_dst_1;
	logic      dex_mem_we;
	logic      dex_mem_re;
	logic      dex_halt;
	reg_addr_t dex_dst_addr_0;
	reg_addr_t dex_dst_addr_1;
	word_t     dex_alu_result;
	word_t     dex_pc_return;
	word_t     dex_mem_addr;
	word_t     dex_mem_wdata;
	word_t     dex_load_immd;

	////////////////////////////////////////////////////////////////////////////
	// Fetch
	////////////////////////////////////////////////////////////////////////////
	assign instr_addr = pc;
	assign pc_plus_1  = pc + word_t'(1);
	// High from the cycle HALT sits in DEX
	assign halted     = halt_q || dex_halt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc     <= '0;
			halt_q <= 1'b0;
		end else begin
			halt_q <= halted;
			if (!halted) begin
				if (pc_select) begin
					pc <= pc_next;
				end else if (!mem_busy && !stall_hazard) begin
					pc <= pc_plus_1;
				end
			end
		end
	end

	decode_execute u_dex (
		.clk (clk), .rst_n (rst_n),
		.instr (instr_data), .pc_plus_1 (pc_plus_1), .stall_mem (mem_busy),
		.wb_we (wb_we), .wb_addr (wb_addr), .wb_data (wb_data),
		.stall_hazard (stall_hazard), .pc_select (pc_select), .pc_next (pc_next),
		.dex_alu_to_reg (dex_alu_to_reg), .dex_pcr_to_reg (dex_pcr_to_reg),
		.dex_mem_to_reg (dex_mem_to_reg), .dex_imm_to_reg (dex_imm_to_reg),
		.dex_reg_we_dst_0 (dex_reg_we_dst_0), .dex_reg_we_dst_1 (dex_reg_we_dst_1),
		.dex_mem_we (dex_mem_we), .dex_mem_re (dex_mem_re), .dex_halt (dex_halt),
		.dex_dst_addr_0 (dex_dst_addr_0), .dex_dst_addr_1 (dex_dst_addr_1),
		.dex_alu_result (dex_alu_result), .dex_pc_return (dex_pc_return),
		.dex_mem_addr (dex_mem_addr), .dex_mem_wdata (dex_mem_wdata),
		.dex_load_immd (dex_load_immd)
	);

	mem_writeback #(
		.ADDR_W (ADDR_W)
	) u_mwb (
		.clk (clk), .rst_n (rst_n),
		.dex_alu_to_reg (dex_alu_to_reg), .dex_pcr_to_reg (dex_pcr_to_reg),
		.dex_mem_to_reg (dex_mem_to_reg), .dex_imm_to_reg (dex_imm_to_reg),
		.dex_reg_we_dst_0 (dex_reg_we_dst_0), .dex_reg_we_dst_1 (dex_reg_we_dst_1),
		.dex_mem_we (dex_mem_we), .dex_mem_re (dex_mem_re),
		.dex_dst_addr_0 (dex_dst_addr_0), .dex_dst_addr_1 (dex_dst_addr_1),
		.dex_alu_result (dex_alu_result), .dex_pc_return (dex_pc_return),
		.dex_mem_addr (dex_mem_addr), .dex_mem_wdata (dex_mem_wdata),
		.dex_load_immd (dex_load_immd),
		.prdata (prdata), .pready (pready),
		.psel (psel), .penable (penable), .pwrite (pwrite),
		.paddr (paddr), .pwdata (pwdata), .mem_busy (mem_busy),
		.wb_we (wb_we), .wb_addr (wb_addr), .wb_data (wb_data)
	);

endmodule

`default_nettype wire

// File: tb_cpu_core.sv
`default_nettype none

module tb_cpu_core;
	import isa_pkg::*;

	localparam int ADDR_W     = apb_pkg::ADDR_W_DEFAULT;
	localparam int CYC_PER_OP = 40;
	localparam int HALT_QUIET = 20;

	logic              clk = 1'b0;
	logic              rst_n;
	word_t             instr_addr;
	word_t             instr_data;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [ADDR_W-1:0] paddr;
	word_t             pwdata;
	word_t             prdata = '0;
	logic              pready = 1'b0;
	logic              halted;

	// Instruction ROM and its fill pointer
	word_t rom [256];
	int    fill;

	// APB memory model state
	word_t             mem [64];
	integer            seed;
	int                wait_left;
	logic [ADDR_W-1:0] wr_addr_q [$];
	word_t             wr_data_q [$];

	// Expected stores in program order
	logic [ADDR_W-1:0] exp_addr_q [$];
	word_t             exp_data_q [$];

	always #50 clk = ~clk;

	assign instr_data = rom[instr_addr[7:0]];

	cpu_core #(
		.ADDR_W (ADDR_W)
	) u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr_addr (instr_addr),
		.instr_data (instr_data),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.halted     (halted)
	);

	function automatic word_t fill_word(input logic [5:0] idx);
		return (word_t'(idx) * 16'h0a57) ^ 16'h5a00;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// APB memory with random wait states
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		int w;
		if (!rst_n) begin
			for (int i = 0; i < 64; i++) begin
				mem[i] <= fill_word(6'(i));
			end
			pready     <= 1'b0;
			wait_left  <= 0;
			wr_addr_q.delete();
			wr_data_q.delete();
		end else if (psel && !penable) begin
			w = int'($unsigned($random(seed)) % 4);
			prdata    <= mem[paddr[5:0]];
			wait_left <= w;
			pready    <= (w == 0);
		end else if (psel && penable) begin
			if (pready) begin
				if (pwrite) begin
					mem[paddr[5:0]] <= pwdata;
					wr_addr_q.push_back(paddr);
					wr_data_q.push_back(pwdata);
				end
				pready     <= 1'b0;
			end else begin
				wait_left <= wait_left - 1;
				pready    <= (wait_left == 1);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reporting and compare tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic fail_now();
		$display("Checks failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			fail_now();
		end
	endtask

	task automatic check_addr(input string what, input logic [ADDR_W-1:0] got,
			input logic [ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			fail_now();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Instruction encoders
	////////////////////////////////////////////////////////////////////////////
	function automatic word_t alu_rr(input opcode_t op, input reg_addr_t ra,
			input reg_addr_t rb);
		return {op, 1'b0, ra, rb};
	endfunction

	function automatic word_t byte_load(input opcode_t op, input logic [2:0] r,
			input logic [7:0] b);
		return {op, r, b};
	endfunction

	function automatic word_t branch_instr(input cond_t c, input logic [7:0] off);
		return {OP_B, c, off};
	endfunction

	function automatic word_t reg_jump(input reg_addr_t rb);
		return {OP_J, 6'b0, rb};
	endfunction

	function automatic word_t imm_jump(input logic [9:0] off);
		return {OP_JI, 1'b0, off};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Program building
	////////////////////////////////////////////////////////////////////////////
	task automatic new_program();
		for (int i = 0; i < 256; i++) begin
			rom[i] = {OP_NOP, 11'b0};
		end
		fill = 0;
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	task automatic emit(input word_t w);
		rom[fill] = w;
		fill++;
	endtask

	// Byte loads carry a 3-bit register field so only R1 to R7
	task automatic set_reg(input logic [2:0] r, input word_t value);
		emit(byte_load(OP_LDU, r, value[15:8]));
		emit(byte_load(OP_LDL, r, value[7:0]));
	endtask

	// R7 holds the store address
	task automatic store_reg(input reg_addr_t src, input logic [5:0] addr,
			input word_t expected);
		set_reg(3'd7, word_t'(addr));
		emit({OP_ST, 1'b0, src, 5'd7});
		exp_addr_q.push_back(ADDR_W'(addr));
		exp_data_q.push_back(expected);
	endtask

	task automatic run_program(input string name);
		int limit;
		int cycles;
		emit({OP_HALT, 11'b0});
		limit = CYC_PER_OP * fill;
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > limit) begin
				$display("Timeout: program %s did not halt within %0d cycles", name, limit);
				fail_now();
			end
		end while (!halted);
		repeat (HALT_QUIET) begin
			@(posedge clk);
			if (psel || !halted) begin
				$display("Program %s: bus activity or halted dropped after HALT", name);
				fail_now();
			end
		end
		if (wr_addr_q.size() != exp_addr_q.size()) begin
			$display("Program %s: %0d stores seen, %0d expected", name,
				wr_addr_q.size(), exp_addr_q.size());
			fail_now();
		end
		foreach (exp_addr_q[i]) begin
			check_addr({name, " store address"}, wr_addr_q[i], exp_addr_q[i]);
			check_word({name, " store data"}, wr_data_q[i], exp_data_q[i]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////
	task automatic test_alu();
		word_t a;
		word_t b;
		a = 16'h7a5c;
		b = 16'h1c3f;
		new_program();
		for (int k = 0; k < 8; k++) begin
			set_reg(3'd1, a);
			set_reg(3'd2, b);
			case (k)
				0: begin
					emit(alu_rr(OP_ADD, 5'd1, 5'd2));
					store_reg(5'd1, 6'(k), a + b);
				end
				1: begin
					emit(alu_rr(OP_SUB, 5'd1, 5'd2));
					store_reg(5'd1, 6'(k), a - b);
				end
				2: begin
					emit(alu_rr(OP_AND, 5'd1, 5'd2));
					store_reg(5'd1, 6'(k), a & b);
				end
				3: begin
					emit(alu_rr(OP_OR, 5'd1, 5'd2));
					store_reg(5'd1, 6'(k), a | b);
				end
				4: begin
					emit(alu_rr(OP_XOR, 5'd1, 5'd2));
					store_reg(5'd1, 6'(k), a ^ b);
				end
				// Shift amount sits in the low four bits
				5: begin
					emit(alu_rr(OP_SLL, 5'd1, 5'd5));
					store_reg(5'd1, 6'(k), a << 5);
				end
				6: begin
					emit(alu_rr(OP_SRL, 5'd1, 5'd3));
					store_reg(5'd1, 6'(k), a >> 3);
				end
				default: begin
					emit(alu_rr(OP_ADDI, 5'd1, 5'b11010));
					store_reg(5'd1, 6'(k), a + 16'hfffa);
				end
			endcase
		end
		run_program("alu");
	endtask

	task automatic test_hazard();
		word_t r1;
		word_t r2;
		new_program();
		r1 = 16'd3;
		r2 = 16'd5;
		set_reg(3'd1, r1);
		set_reg(3'd2, r2);
		emit(alu_rr(OP_ADD, 5'd1, 5'd2));
		r1 = r1 + r2;
		emit(alu_rr(OP_ADD, 5'd1, 5'd1));
		r1 = r1 + r1;
		emit(alu_rr(OP_SUB, 5'd1, 5'd2));
		r1 = r1 - r2;
		emit(alu_rr(OP_XOR, 5'd2, 5'd1));
		r2 = r2 ^ r1;
		emit(alu_rr(OP_ADD, 5'd2, 5'd2));
		r2 = r2 + r2;
		store_reg(5'd1, 6'd8, r1);
		store_reg(5'd2, 6'd9, r2);
		run_program("hazard");
	endtask

	task automatic test_loads();
		new_program();
		emit(byte_load(OP_LDU, 3'd3, 8'hab));
		emit(byte_load(OP_LDL, 3'd3, 8'hcd));
		store_reg(5'd3, 6'd10, 16'habcd);
		emit(byte_load(OP_LDL, 3'd3, 8'h11));
		store_reg(5'd3, 6'd11, 16'hab11);
		emit(byte_load(OP_LDU, 3'd3, 8'h22));
		store_reg(5'd3, 6'd12, 16'h2211);
		set_reg(3'd4, 16'h0020);
		emit({OP_LD, 1'b0, 5'd5, 5'd4});
		store_reg(5'd5, 6'd13, fill_word(6'h20));
		// Use of the loaded value right after the load
		emit({OP_LD, 1'b0, 5'd5, 5'd4});
		emit(alu_rr(OP_ADD, 5'd5, 5'd5));
		store_reg(5'd5, 6'd14, fill_word(6'h20) + fill_word(6'h20));
		run_program("loads");
	endtask

	function automatic logic cond_after_sub(input cond_t c, input word_t a, input word_t b);
		word_t d;
		logic  z;
		logic  n;
		logic  v;
		d = a - b;
		z = (d == 16'd0);
		n = d[15];
		v = (a[15] != b[15]) && (d[15] != a[15]);
		case (c)
			COND_EQ: return z;
			COND_NE: return !z;
			COND_LT: return n != v;
			COND_GE: return n == v;
			COND_GT: return !z && (n == v);
			COND_LE: return z || (n != v);
			COND_OV: return v;
			default: return 1'b1;
		endcase
	endfunction

	task automatic branch_case(input cond_t c, input word_t a, input word_t b,
			input logic [5:0] addr);
		set_reg(3'd6, 16'h00aa);
		set_reg(3'd1, a);
		set_reg(3'd2, b);
		emit(alu_rr(OP_SUB, 5'd1, 5'd2));
		// Taken skips the marker overwrite
		emit(branch_instr(c, 8'd1));
		emit(byte_load(OP_LDL, 3'd6, 8'hbb));
		store_reg(5'd6, addr, cond_after_sub(c, a, b) ? 16'h00aa : 16'h00bb);
	endtask

	task automatic test_branches();
		new_program();
		branch_case(COND_EQ, 16'd5, 16'd5, 6'd16);
		branch_case(COND_EQ, 16'd5, 16'd3, 6'd17);
		branch_case(COND_LT, 16'd3, 16'd5, 6'd18);
		branch_case(COND_GE, 16'd3, 16'd5, 6'd19);
		branch_case(COND_GT, 16'd5, 16'd3, 6'd20);
		branch_case(COND_OV, 16'h7fff, 16'hffff, 6'd21);
		run_program("branches");
	endtask

	task automatic test_jumps();
		int p;
		int t;
		new_program();
		set_reg(3'd6, 16'h00aa);
		p = fill;
		emit(imm_jump(10'd2));
		emit(byte_load(OP_LDL, 3'd6, 8'hee));
		emit(byte_load(OP_LDL, 3'd6, 8'hef));
		store_reg(5'd16, 6'd24, word_t'(p + 1));
		store_reg(5'd6, 6'd25, 16'h00aa);
		// Target lies past set_reg, J and one skipped instruction
		t = fill + 4;
		set_reg(3'd5, word_t'(t));
		emit(reg_jump(5'd5));
		emit(byte_load(OP_LDL, 3'd6, 8'hee));
		store_reg(5'd16, 6'd26, word_t'(t - 1));
		store_reg(5'd6, 6'd27, 16'h00aa);
		run_program("jumps");
	endtask

	initial begin
		rst_n       = 1'b0;
		seed        = 32'h3c69_34ca;
		new_program();
		test_alu();
		test_hazard();
		test_loads();
		test_branches();
		test_jumps();
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
apb_pkg.sv
isa_pkg.sv
control_unit.sv
register_file.sv
alu.sv
branch_unit.sv
decode_execute.sv
mem_writeback.sv
cpu_core.sv
tb_cpu_core.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   := sources.f
TOP        := tb_cpu_core
RTL_TOP    := cpu_core
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
